//--- datapathCore.f
verilog/datapathPkg.sv
verilog/flowPkg.sv
verilog/cmdQueue.sv
verilog/operandFetch.sv
verilog/aluStage.sv
verilog/regFile.sv
verilog/portArbiter.sv
verilog/datapathCore.sv
bench/datapathCore_chk.sv
bench/datapathCore_tb.sv

//--- run.sh
#!/bin/sh
# build the datapath core testbench with Verilator, run it and judge the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module datapathCore_tb -Mdir obj_dir -f datapathCore.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/VdatapathCore_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

//--- bench/datapathCore_tb.sv
// testbench for the datapath core with stimulus table, credit tracking and result checks
module datapathCore_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [2:0]          test;
        datapathPkg::cmdT    cmd;
        datapathPkg::resultT exp;
    } stepT;

    // short names for the table columns
    localparam datapathPkg::aluOpT load = datapathPkg::opLoad;
    localparam datapathPkg::aluOpT move = datapathPkg::opTransfer;
    localparam datapathPkg::aluOpT adc = datapathPkg::opAdc;
    localparam datapathPkg::aluOpT andA = datapathPkg::opAnd;
    localparam datapathPkg::aluOpT eorA = datapathPkg::opEor;
    localparam datapathPkg::aluOpT oraA = datapathPkg::opOra;
    localparam datapathPkg::aluOpT ror = datapathPkg::opRor;
    localparam datapathPkg::aluOpT setF = datapathPkg::opSetFlags;
    localparam datapathPkg::regSelT ra = datapathPkg::regA;
    localparam datapathPkg::regSelT rx = datapathPkg::regX;
    localparam datapathPkg::regSelT ry = datapathPkg::regY;

    logic rstAll;
    logic rstN;
    logic cmdValid;
    datapathPkg::cmdT cmd;
    logic creditReturn;
    logic resValid;
    datapathPkg::resultT res;

    stepT steps[$];
    datapathPkg::resultT expQ[$];
    string testNames [1:6] = '{"load and transfer", "binary adc", "logic ops",
        "rotate right", "decimal adc", "credit burst"};
    logic [31:0] lfsr = 32'hf50a06ff;
    flowPkg::creditCntT credits;
    flowPkg::creditCntT minCredits;
    logic heldReturn;
    int sentCount;
    int returnCount;
    int checkCount;
    int errorCount;
    int failingTests;
    int assertFails;
    int cycleCount;
    int cycleLimit;

    datapathCore i_datapathCore (
        .rstAll(rstAll), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd),
        .creditReturn(creditReturn), .resValid(resValid), .res(res)
    );

    bind datapathCore datapathCore_chk i_chk (
        .rstAll(rstAll), .rstN(rstN), .cmdValid(cmdValid),
        .creditReturn(creditReturn), .resValid(resValid)
    );

    always #4 rstAll = ~rstAll;

    // run limit counted in clock cycles
    always @(posedge rstAll) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsrNext(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic addStep(input int test, input datapathPkg::aluOpT op,
                           input datapathPkg::regSelT dst, input datapathPkg::regSelT src,
                           input datapathPkg::byteT imm, input datapathPkg::byteT data,
                           input datapathPkg::flagsT flags);
        stepT s;
        s.test = 3'(test);
        s.cmd.op = op;
        s.cmd.dst = dst;
        s.cmd.src = src;
        s.cmd.imm = imm;
        s.exp.data = data;
        s.exp.flags = flags;
        steps.push_back(s);
    endtask

    // columns are test, op, dst, src, imm, expected byte, expected flags n v d z c
    task automatic fillSteps();
        addStep(1, load, ra, ra, 8'h80, 8'h80, 5'b10000);
        addStep(1, move, rx, ra, 8'h00, 8'h80, 5'b10000);
        addStep(1, load, ry, ra, 8'h00, 8'h00, 5'b00010);
        addStep(1, move, ra, ry, 8'h00, 8'h00, 5'b00010);
        addStep(1, move, ry, rx, 8'h00, 8'h80, 5'b10000);
        addStep(1, load, rx, ra, 8'h5a, 8'h5a, 5'b00000);
        // setFlags leaves Z and N alone even with A at zero
        addStep(2, setF, ra, ra, 8'h00, 8'h00, 5'b00000);
        addStep(2, load, ra, ra, 8'h50, 8'h50, 5'b00000);
        addStep(2, load, rx, ra, 8'h50, 8'h50, 5'b00000);
        addStep(2, adc, ra, rx, 8'h00, 8'ha0, 5'b11000);
        addStep(2, load, ry, ra, 8'h70, 8'h70, 5'b01000);
        addStep(2, adc, ra, ry, 8'h00, 8'h10, 5'b00001);
        addStep(2, setF, ra, ra, 8'h01, 8'h10, 5'b00001);
        addStep(2, load, rx, ra, 8'hef, 8'hef, 5'b10001);
        addStep(2, adc, ra, rx, 8'h00, 8'h00, 5'b00011);
        addStep(2, adc, ra, rx, 8'h00, 8'hf0, 5'b10000);
        addStep(3, load, ra, ra, 8'h7f, 8'h7f, 5'b00000);
        addStep(3, load, rx, ra, 8'h01, 8'h01, 5'b00000);
        addStep(3, adc, ra, rx, 8'h00, 8'h80, 5'b11000);
        addStep(3, setF, ra, ra, 8'h01, 8'h80, 5'b11001);
        addStep(3, load, ry, ra, 8'h0f, 8'h0f, 5'b01001);
        addStep(3, load, rx, ra, 8'hf0, 8'hf0, 5'b11001);
        addStep(3, andA, ra, ry, 8'h00, 8'h00, 5'b01011);
        addStep(3, oraA, ra, rx, 8'h00, 8'hf0, 5'b11001);
        addStep(3, eorA, ra, rx, 8'h00, 8'h00, 5'b01011);
        addStep(3, oraA, ra, ry, 8'h00, 8'h0f, 5'b01001);
        addStep(3, eorA, ra, rx, 8'h00, 8'hff, 5'b11001);
        addStep(3, andA, ra, rx, 8'h00, 8'hf0, 5'b11001);
        addStep(4, load, rx, ra, 8'h01, 8'h01, 5'b01001);
        addStep(4, ror, rx, rx, 8'h00, 8'h80, 5'b11001);
        addStep(4, ror, rx, rx, 8'h00, 8'hc0, 5'b11000);
        addStep(4, ror, rx, rx, 8'h00, 8'h60, 5'b01000);
        addStep(4, ror, ra, ry, 8'h00, 8'h07, 5'b01001);
        addStep(4, ror, ry, ry, 8'h00, 8'h87, 5'b11001);
        addStep(4, setF, ra, ra, 8'h00, 8'h07, 5'b11000);
        addStep(4, ror, ra, ra, 8'h00, 8'h03, 5'b01001);
        addStep(4, ror, ra, ra, 8'h00, 8'h81, 5'b11001);
        addStep(5, setF, ra, ra, 8'h09, 8'h81, 5'b11101);
        addStep(5, setF, ra, ra, 8'h08, 8'h81, 5'b11100);
        addStep(5, load, ra, ra, 8'h15, 8'h15, 5'b01100);
        addStep(5, load, rx, ra, 8'h27, 8'h27, 5'b01100);
        addStep(5, adc, ra, rx, 8'h00, 8'h42, 5'b00100);
        addStep(5, load, ry, ra, 8'h58, 8'h58, 5'b00100);
        addStep(5, adc, ra, ry, 8'h00, 8'h00, 5'b01111);
        addStep(5, load, rx, ra, 8'h99, 8'h99, 5'b11101);
        addStep(5, adc, ra, rx, 8'h00, 8'h00, 5'b00111);
        addStep(5, load, ra, ra, 8'h19, 8'h19, 5'b00101);
        addStep(5, adc, ra, rx, 8'h00, 8'h19, 5'b00101);
        addStep(5, setF, ra, ra, 8'h00, 8'h19, 5'b00000);
        addStep(6, load, ra, ra, 8'h01, 8'h01, 5'b00000);
        addStep(6, load, rx, ra, 8'h02, 8'h02, 5'b00000);
        addStep(6, load, ry, ra, 8'h03, 8'h03, 5'b00000);
        addStep(6, oraA, ra, rx, 8'h00, 8'h03, 5'b00000);
        addStep(6, eorA, ra, ry, 8'h00, 8'h00, 5'b00010);
        addStep(6, move, rx, ry, 8'h00, 8'h03, 5'b00000);
        addStep(6, adc, ra, rx, 8'h00, 8'h03, 5'b00000);
        addStep(6, ror, ry, ra, 8'h00, 8'h01, 5'b00001);
        addStep(6, adc, ra, ry, 8'h00, 8'h05, 5'b00000);
        addStep(6, move, ry, ra, 8'h00, 8'h05, 5'b00000);
        addStep(6, eorA, ra, rx, 8'h00, 8'h06, 5'b00000);
        addStep(6, andA, ra, ry, 8'h00, 8'h04, 5'b00000);
    endtask

    task automatic checkResult();
        datapathPkg::resultT expected;
        if (expQ.size() == 0) begin
            errorCount++;
            $display("a result arrived while no command was outstanding");
        end else begin
            expected = expQ.pop_front();
            compareValue("res.data", {24'b0, res.data}, {24'b0, expected.data});
            compareValue("res.flags", {27'b0, res.flags}, {27'b0, expected.flags});
        end
    endtask

    // outputs are sampled on the falling edge before new inputs are driven
    task automatic nextCycle();
        @(negedge rstAll);
        // a credit seen last cycle may be spent from this cycle on
        if (heldReturn) begin
            credits = credits + 3'd1;
        end
        heldReturn = creditReturn;
        if (creditReturn) begin
            returnCount++;
        end
        if (resValid) begin
            checkResult();
        end
    endtask

    task automatic idleCycle();
        cmdValid = 1'b0;
        nextCycle();
    endtask

    task automatic sendCommand(input stepT s);
        while (credits == 0) begin
            idleCycle();
        end
        cmdValid = 1'b1;
        cmd = s.cmd;
        credits = credits - 3'd1;
        if (credits < minCredits) begin
            minCredits = credits;
        end
        sentCount++;
        expQ.push_back(s.exp);
        nextCycle();
        cmdValid = 1'b0;
    endtask

    task automatic runTest(input int test);
        int errorsBefore;
        int gap;
        int extra;
        errorsBefore = errorCount;
        minCredits = flowPkg::creditCntT'(flowPkg::cmdCredits);
        foreach (steps[i]) begin
            if (steps[i].test == 3'(test)) begin
                // one or two idle cycles before about a quarter of the burst steps
                if (test == 6) begin
                    takeBits(2, gap);
                    if (gap == 3) begin
                        takeBits(1, extra);
                        gap = 1 + extra;
                    end else begin
                        gap = 0;
                    end
                    repeat (gap) idleCycle();
                end
                sendCommand(steps[i]);
            end
        end
        // drain results and collect the outstanding credits
        while (expQ.size() != 0 || credits < flowPkg::cmdCredits) begin
            idleCycle();
        end
        compareValue("credits", {29'b0, credits}, flowPkg::cmdCredits);
        if (test == 6) begin
            compareValue("creditReturn pulses", returnCount, sentCount);
            compareValue("lowest credit count", {29'b0, minCredits}, 32'd0);
        end
        if (errorCount != errorsBefore) begin
            failingTests++;
        end
        $display("test %0d %s: %0d errors", test, testNames[test], errorCount - errorsBefore);
    endtask

    initial begin
        rstAll = 1'b0;
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        credits = flowPkg::creditCntT'(flowPkg::cmdCredits);
        minCredits = credits;
        heldReturn = 1'b0;
        fillSteps();
        cycleLimit = steps.size() * 8 + 64;
        repeat (2) @(negedge rstAll);
        rstN = 1'b1;
        for (int t = 1; t <= 6; t++) begin
            runTest(t);
        end
        assertFails = i_datapathCore.i_chk.failCount;
        $display("summary: 6 tests, %0d failing, %0d checks, %0d errors, %0d assertion failures",
                 failingTests, checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- bench/datapathCore_chk.sv
// bound assertions on command credits, queue occupancy and outputs under reset
module datapathCore_chk (
    input logic rstAll,
    input logic rstN,
    input logic cmdValid,
    input logic creditReturn,
    input logic resValid
);
    timeunit 1ns;
    timeprecision 1ps;

    flowPkg::creditCntT occupancy;
    int failCount;

    // queue entries as seen from the command interface
    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            occupancy <= '0;
        end else if (cmdValid && !creditReturn) begin
            occupancy <= occupancy + 3'd1;
        end else if (creditReturn && !cmdValid) begin
            occupancy <= occupancy - 3'd1;
        end
    end

    noPushWhenFull: assert property (@(posedge rstAll) disable iff (!rstN)
        cmdValid |-> (occupancy < flowPkg::creditCntT'(flowPkg::cmdCredits)))
    else begin
        failCount++;
        $error("cmdValid while the command queue is full");
    end

    noReturnWhenEmpty: assert property (@(posedge rstAll) disable iff (!rstN)
        creditReturn |-> (occupancy != '0))
    else begin
        failCount++;
        $error("creditReturn while the command queue is empty");
    end

    quietInReset: assert property (@(posedge rstAll)
        !rstN |-> (!creditReturn && !resValid))
    else begin
        failCount++;
        $error("output active during reset");
    end

endmodule

//--- verilog/datapathCore.sv
// datapath core top, queue, fetch, ALU, arbiter and register file wiring
module datapathCore (
    input  logic                rstAll,
    input  logic                rstN,
    input  logic                cmdValid,
    input  datapathPkg::cmdT    cmd,
    output logic                creditReturn,
    output logic                resValid,
    output datapathPkg::resultT res
);
    logic qValid;
    logic qTake;
    datapathPkg::cmdT qCmd;
    logic aluFree;
    logic fetchGnt;
    logic writeGnt;
    logic portWe;
    logic issueValid;
    datapathPkg::cmdT issueCmd;
    flowPkg::portRdT issueOps;
    flowPkg::portRdT rdData;
    flowPkg::portReqT fetchReq;
    flowPkg::portReqT writeReq;
    flowPkg::portReqT portReq;

    cmdQueue i_cmdQueue (
        .rstAll(rstAll), .rstN(rstN), .cmdValid(cmdValid), .cmd(cmd),
        .qTake(qTake), .qValid(qValid), .qCmd(qCmd), .creditReturn(creditReturn)
    );

    operandFetch i_operandFetch (
        .rstAll(rstAll), .rstN(rstN), .qValid(qValid), .qCmd(qCmd), .qTake(qTake),
        .aluFree(aluFree), .fetchReq(fetchReq), .fetchGnt(fetchGnt), .rdData(rdData),
        .issueValid(issueValid), .issueCmd(issueCmd), .issueOps(issueOps)
    );

    aluStage i_aluStage (
        .rstAll(rstAll), .rstN(rstN), .issueValid(issueValid), .issueCmd(issueCmd),
        .issueOps(issueOps), .aluFree(aluFree), .writeReq(writeReq), .writeGnt(writeGnt),
        .resValid(resValid), .res(res)
    );

    portArbiter i_portArbiter (
        .rstAll(rstAll), .rstN(rstN), .fetchReq(fetchReq), .writeReq(writeReq),
        .fetchGnt(fetchGnt), .writeGnt(writeGnt), .portReq(portReq), .portWe(portWe)
    );

    regFile i_regFile (
        .rstAll(rstAll), .rstN(rstN), .portReq(portReq), .portWe(portWe), .rdData(rdData)
    );

endmodule

//--- verilog/portArbiter.sv
// register-port arbiter, alternates between writeback and fetch under contention
module portArbiter (
    input  logic             rstAll,
    input  logic             rstN,
    input  flowPkg::portReqT fetchReq,
    input  flowPkg::portReqT writeReq,
    output logic             fetchGnt,
    output logic             writeGnt,
    output flowPkg::portReqT portReq,
    output logic             portWe
);
    flowPkg::portOwnerT lastOwner;

    // on a tie the side that lost last time wins, writeback first after reset
    always_comb begin
        writeGnt = writeReq.req && (!fetchReq.req || (lastOwner != flowPkg::ownerWrite));
        fetchGnt = fetchReq.req && !writeGnt;
        portReq = writeGnt ? writeReq : fetchReq;
        portWe = writeGnt && writeReq.write;
    end

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            lastOwner <= flowPkg::ownerNone;
        end else if (writeGnt) begin
            lastOwner <= flowPkg::ownerWrite;
        end else if (fetchGnt) begin
            lastOwner <= flowPkg::ownerFetch;
        end
    end

endmodule

//--- verilog/regFile.sv
// A, X, Y and status registers behind one shared read/write port
module regFile (
    input  logic             rstAll,
    input  logic             rstN,
    input  flowPkg::portReqT portReq,
    input  logic             portWe,
    output flowPkg::portRdT  rdData
);
    datapathPkg::byteT aReg;
    datapathPkg::byteT xReg;
    datapathPkg::byteT yReg;
    datapathPkg::flagsT status;

    // a write stores the byte into dst and replaces all flags
    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            aReg <= '0;
            xReg <= '0;
            yReg <= '0;
            status <= '0;
        end else if (portWe) begin
            case (portReq.dst)
                datapathPkg::regA: aReg <= portReq.data;
                datapathPkg::regX: xReg <= portReq.data;
                datapathPkg::regY: yReg <= portReq.data;
                default: aReg <= aReg;
            endcase
            status <= portReq.flags;
        end
    end

    // read is combinational, A always comes along with the source
    always_comb begin
        rdData.aVal = aReg;
        rdData.flags = status;
        case (portReq.src)
            datapathPkg::regX: rdData.srcVal = xReg;
            datapathPkg::regY: rdData.srcVal = yReg;
            default: rdData.srcVal = aReg;
        endcase
    end

endmodule

//--- verilog/aluStage.sv
// ALU with decimal adjust, flag update and adder hold register awaiting writeback
module aluStage (
    input  logic                rstAll,
    input  logic                rstN,
    input  logic                issueValid,
    input  datapathPkg::cmdT    issueCmd,
    input  flowPkg::portRdT     issueOps,
    output logic                aluFree,
    output flowPkg::portReqT    writeReq,
    input  logic                writeGnt,
    output logic                resValid,
    output datapathPkg::resultT res
);
    typedef enum logic [1:0] {
        aluIdle,
        aluCompute,
        aluHold
    } aluStateT;

    aluStateT state;
    datapathPkg::cmdT opCmd;
    flowPkg::portRdT opOps;
    datapathPkg::resultT holdRes;
    datapathPkg::regSelT holdDst;
    datapathPkg::resultT nextRes;
    datapathPkg::regSelT nextDst;
    logic halfCarry;
    logic sumCarry;
    logic [3:0] lowSum;
    logic [3:0] highSum;
    datapathPkg::byteT adcSum;

    // a new command may read only once the previous one is written back
    assign aluFree = (state == aluIdle);

    // two nibble sums where the low digit carry gives the half carry
    always_comb begin
        {halfCarry, lowSum} = {1'b0, opOps.aVal[3:0]} + {1'b0, opOps.srcVal[3:0]}
            + {4'b0, opOps.flags.c};
        {sumCarry, highSum} = {1'b0, opOps.aVal[7:4]} + {1'b0, opOps.srcVal[7:4]}
            + {4'b0, halfCarry};
        adcSum = {highSum, lowSum};
    end

    always_comb begin
        nextRes.data = opOps.aVal;
        nextRes.flags = opOps.flags;
        nextDst = datapathPkg::regA;
        case (opCmd.op)
            datapathPkg::opLoad: begin
                nextRes.data = opCmd.imm;
                nextDst = opCmd.dst;
            end
            datapathPkg::opTransfer: begin
                nextRes.data = opOps.srcVal;
                nextDst = opCmd.dst;
            end
            datapathPkg::opAdc: begin
                nextRes.data = adcSum;
                nextRes.flags.c = sumCarry;
                nextRes.flags.v = (opOps.aVal[7] == opOps.srcVal[7])
                    && (adcSum[7] != opOps.aVal[7]);
                // decimal adjust looks at the unadjusted binary sum
                if (opOps.flags.d) begin
                    if ((lowSum > datapathPkg::bcdLimit) || halfCarry) begin
                        nextRes.data = nextRes.data + {4'h0, datapathPkg::bcdAdjust};
                    end
                    if (sumCarry || (adcSum > 8'h99)) begin
                        nextRes.data = nextRes.data + {datapathPkg::bcdAdjust, 4'h0};
                        nextRes.flags.c = 1'b1;
                    end
                end
            end
            datapathPkg::opAnd: nextRes.data = opOps.aVal & opOps.srcVal;
            datapathPkg::opEor: nextRes.data = opOps.aVal ^ opOps.srcVal;
            datapathPkg::opOra: nextRes.data = opOps.aVal | opOps.srcVal;
            datapathPkg::opRor: begin
                // carry enters at bit 7 and bit 0 leaves into carry
                nextRes.data = {opOps.flags.c, opOps.srcVal[7:1]};
                nextRes.flags.c = opOps.srcVal[0];
                nextDst = opCmd.dst;
            end
            datapathPkg::opSetFlags: begin
                nextRes.flags.c = opCmd.imm[0];
                nextRes.flags.d = opCmd.imm[3];
            end
        endcase
        // setFlags rewrites A unchanged and keeps Z and N
        if (opCmd.op != datapathPkg::opSetFlags) begin
            nextRes.flags.z = (nextRes.data == '0);
            nextRes.flags.n = nextRes.data[7];
        end
    end

    always_comb begin
        writeReq.req = (state == aluHold);
        writeReq.write = 1'b1;
        writeReq.dst = holdDst;
        writeReq.src = datapathPkg::regA;
        writeReq.data = holdRes.data;
        writeReq.flags = holdRes.flags;
    end

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            state <= aluIdle;
            resValid <= 1'b0;
        end else begin
            case (state)
                aluIdle: if (issueValid) state <= aluCompute;
                aluCompute: state <= aluHold;
                aluHold: if (writeGnt) state <= aluIdle;
                default: state <= aluIdle;
            endcase
            resValid <= (state == aluHold) && writeGnt;
        end
    end

    always_ff @(posedge rstAll) begin
        if (issueValid) begin
            opCmd <= issueCmd;
            opOps <= issueOps;
        end
        if (state == aluCompute) begin
            holdRes <= nextRes;
            holdDst <= nextDst;
        end
        if ((state == aluHold) && writeGnt) begin
            res <= holdRes;
        end
    end

endmodule

//--- verilog/operandFetch.sv
// command holding slot and register-port read request for its operands
module operandFetch (
    input  logic             rstAll,
    input  logic             rstN,
    input  logic             qValid,
    input  datapathPkg::cmdT qCmd,
    output logic             qTake,
    input  logic             aluFree,
    output flowPkg::portReqT fetchReq,
    input  logic             fetchGnt,
    input  flowPkg::portRdT  rdData,
    output logic             issueValid,
    output datapathPkg::cmdT issueCmd,
    output flowPkg::portRdT  issueOps
);
    logic slotValid;
    datapathPkg::cmdT slotCmd;

    // issue happens in the same cycle the read is granted
    assign issueValid = slotValid && fetchGnt;
    assign issueCmd = slotCmd;
    assign issueOps = rdData;

    // slot accepts a new command when empty or emptying now
    assign qTake = !slotValid || issueValid;

    always_comb begin
        fetchReq.req = slotValid && aluFree;
        fetchReq.write = 1'b0;
        fetchReq.dst = slotCmd.dst;
        fetchReq.src = slotCmd.src;
        fetchReq.data = '0;
        fetchReq.flags = '0;
    end

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            slotValid <= 1'b0;
        end else if (qTake) begin
            slotValid <= qValid;
        end
    end

    always_ff @(posedge rstAll) begin
        if (qTake && qValid) begin
            slotCmd <= qCmd;
        end
    end

endmodule

//--- verilog/cmdQueue.sv
// command FIFO with credit return on every entry taken
module cmdQueue (
    input  logic             rstAll,
    input  logic             rstN,
    input  logic             cmdValid,
    input  datapathPkg::cmdT cmd,
    input  logic             qTake,
    output logic             qValid,
    output datapathPkg::cmdT qCmd,
    output logic             creditReturn
);
    typedef logic [$clog2(flowPkg::cmdCredits)-1:0] ptrT;

    datapathPkg::cmdT mem [flowPkg::cmdCredits];
    ptrT wrPtr;
    ptrT rdPtr;
    flowPkg::creditCntT count;
    logic push;
    logic pop;

    // sender only pushes with a credit in hand, full check is a safety net
    assign push = cmdValid && (count != flowPkg::creditCntT'(flowPkg::cmdCredits));
    assign pop = qValid && qTake;

    assign qValid = (count != '0);
    assign qCmd = mem[rdPtr];
    assign creditReturn = pop;

    always_ff @(posedge rstAll or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrT'(flowPkg::cmdCredits - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrT'(flowPkg::cmdCredits - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge rstAll) begin
        if (push) begin
            mem[wrPtr] <= cmd;
        end
    end

endmodule

//--- verilog/flowPkg.sv
// credit depth, credit counter, register-port request and read structs, port owner enum
package flowPkg;

    // queue depth and initial sender credits
    localparam int cmdCredits = 4;

    typedef logic [2:0] creditCntT;

    typedef enum logic [1:0] {
        ownerNone,
        ownerFetch,
        ownerWrite
    } portOwnerT;

    // req marks a live request, write selects a store over a read
    typedef struct packed {
        logic                req;
        logic                write;
        datapathPkg::regSelT dst;
        datapathPkg::regSelT src;
        datapathPkg::byteT   data;
        datapathPkg::flagsT  flags;
    } portReqT;

    typedef struct packed {
        datapathPkg::byteT  aVal;
        datapathPkg::byteT  srcVal;
        datapathPkg::flagsT flags;
    } portRdT;

endpackage

//--- verilog/datapathPkg.sv
// data byte, register and operation enums, flag, command and result structs, BCD constants
package datapathPkg;

    typedef logic [7:0] byteT;

    typedef enum logic [1:0] {
        regA,
        regX,
        regY
    } regSelT;

    typedef enum logic [2:0] {
        opLoad,
        opTransfer,
        opAdc,
        opAnd,
        opEor,
        opOra,
        opRor,
        opSetFlags
    } aluOpT;

    // status bits kept by the core, I and B are not modelled
    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic z;
        logic c;
    } flagsT;

    typedef struct packed {
        aluOpT  op;
        regSelT dst;
        regSelT src;
        byteT   imm;
    } cmdT;

    typedef struct packed {
        byteT  data;
        flagsT flags;
    } resultT;

    // decimal adjust constants, per digit
    localparam logic [3:0] bcdLimit = 4'd9;
    localparam logic [3:0] bcdAdjust = 4'd6;

endpackage
